// File: hw/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data path width
`define CORE_XLEN 32

// register index, 32 registers
`define CORE_REG_ADDR_W 5

// opcode and funct fields of the instruction word
`define CORE_OP_W 6

// word address into the data RAM
`define CORE_DMEM_ADDR_W 6
`define CORE_DMEM_DEPTH (1 << `CORE_DMEM_ADDR_W)

// cycles a load or store spends waiting on memory
`define CORE_MEM_WAIT 4

`endif

// File: hw/core_pkg.sv
package core_pkg;

`include "core_consts.svh"

typedef logic [`CORE_XLEN-1:0]        word_t;
typedef logic [`CORE_REG_ADDR_W-1:0]  reg_idx_t;
typedef logic [`CORE_OP_W-1:0]        opcode_t;
typedef logic [`CORE_OP_W-1:0]        funct_t;
typedef logic [`CORE_DMEM_ADDR_W-1:0] dmem_addr_t;

// alu operation codes
typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_xor = 4'd4,
    alu_and = 4'd5,
    alu_or  = 4'd6,
    alu_nor = 4'd7,
    alu_srl = 4'd8,
    alu_sll = 4'd9,
    alu_sra = 4'd10,
    alu_eq  = 4'd12
} alu_op_t;

typedef enum logic [2:0] {
    s_idle,
    s_exec,
    s_mem_wait,
    s_retire,
    s_halted
} exec_state_t;

// alu operand b source
typedef enum logic [2:0] {
    b_rt,
    b_imm_sext,
    b_imm_zext,
    b_shamt,
    b_rs
} b_sel_t;

typedef struct packed {
    word_t word;
    word_t pc;
} instr_in_t;

typedef struct packed {
    alu_op_t  alu_op;
    logic     a_is_rt;     // shifts operate on rt
    b_sel_t   b_sel;
    logic     wr_en;
    reg_idx_t wr_reg;
    logic     is_load;
    logic     is_store;
    logic     is_lui;
    logic     branch_eq;
    logic     branch_ne;
    logic     is_jump;
    logic     halt;
} ctrl_t;

typedef struct packed {
    logic     wr_en;
    reg_idx_t wr_reg;
    word_t    wr_data;
    logic     redirect_en;
    word_t    redirect_pc;
} retire_t;

endpackage

// File: hw/alu.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module alu import core_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   y,
    output logic    zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add: y = a + b;
            alu_sub: y = a - b;
            alu_and: y = a & b;
            alu_or:  y = a | b;
            alu_xor: y = a ^ b;
            alu_nor: y = ~(a | b);
            alu_sll: y = a << shamt;
            alu_srl: y = a >> shamt;
            alu_sra: y = word_t'($signed(a) >>> shamt);
            alu_eq:  y = {{(`CORE_XLEN-1){1'b0}}, a == b};  // 1 when equal
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_b,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    output word_t    rs_data,
    output word_t    rt_data,
    input  logic     wr_en,
    input  reg_idx_t wr_reg,
    input  word_t    wr_data
);

    localparam int NUM_REGS = 1 << `CORE_REG_ADDR_W;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_reg != '0) begin  // $zero never written
            regs[wr_reg] <= wr_data;
        end
    end

    assign rs_data = (rs == '0) ? '0 : regs[rs];
    assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

// File: hw/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import core_pkg::*; (
    input  word_t word,
    output ctrl_t ctrl
);

    opcode_t  op;
    funct_t   fn;
    reg_idx_t rt;
    reg_idx_t rd;

    assign op = word[31:26];
    assign fn = word[5:0];
    assign rt = word[20:16];
    assign rd = word[15:11];

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = alu_add;
        ctrl.b_sel = b_rt;
        if (op == 6'b000000) begin
            // r-type writes rd
            ctrl.wr_en = 1'b1;
            ctrl.wr_reg = rd;
            case (fn)
                6'b100000, 6'b100001: ctrl.alu_op = alu_add;  // add, addu
                6'b100010, 6'b100011: ctrl.alu_op = alu_sub;  // sub, subu
                6'b100100: ctrl.alu_op = alu_and;
                6'b100101: ctrl.alu_op = alu_or;
                6'b100110: ctrl.alu_op = alu_xor;
                6'b100111: ctrl.alu_op = alu_nor;
                6'b000000, 6'b000010, 6'b000011: begin   // sll, srl, sra
                    ctrl.a_is_rt = 1'b1;
                    ctrl.b_sel = b_shamt;
                    ctrl.alu_op = (fn[1:0] == 2'b00) ? alu_sll :
                                  (fn[1:0] == 2'b10) ? alu_srl : alu_sra;
                end
                6'b000100, 6'b000110: begin              // sllv, srlv
                    ctrl.a_is_rt = 1'b1;
                    ctrl.b_sel = b_rs;
                    ctrl.alu_op = fn[1] ? alu_srl : alu_sll;
                end
                default: begin                           // syscall lands here too
                    ctrl.wr_en = 1'b0;
                    ctrl.halt = 1'b1;
                end
            endcase
        end else begin
            ctrl.wr_reg = rt;
            case (op)
                6'b001000, 6'b001001: begin              // addi, addiu both sign extend
                    ctrl.wr_en = 1'b1;
                    ctrl.b_sel = b_imm_sext;
                end
                6'b001100, 6'b001101, 6'b001110: begin   // andi, ori, xori
                    ctrl.wr_en = 1'b1;
                    ctrl.b_sel = b_imm_zext;
                    ctrl.alu_op = (op[1:0] == 2'b00) ? alu_and :
                                  (op[1:0] == 2'b01) ? alu_or : alu_xor;
                end
                6'b001111: begin                         // lui
                    ctrl.wr_en = 1'b1;
                    ctrl.is_lui = 1'b1;
                end
                6'b100011: begin                         // lw
                    ctrl.wr_en = 1'b1;
                    ctrl.is_load = 1'b1;
                    ctrl.b_sel = b_imm_sext;
                end
                6'b101011: begin                         // sw
                    ctrl.is_store = 1'b1;
                    ctrl.b_sel = b_imm_sext;
                end
                6'b000100, 6'b000101: begin              // beq, bne
                    ctrl.alu_op = alu_eq;
                    ctrl.branch_eq = ~op[0];
                    ctrl.branch_ne = op[0];
                end
                6'b000010: ctrl.is_jump = 1'b1;
                default:   ctrl.halt = 1'b1;
            endcase
        end
    end

endmodule

// File: hw/mem_wait_timer.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module mem_wait_timer import core_pkg::*; (
    input  logic clk,
    input  logic rst_b,
    input  logic start,
    output logic done
);

    localparam int CNT_W = $clog2(`CORE_MEM_WAIT + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= CNT_W'(`CORE_MEM_WAIT);
        end else if (cnt != '0) begin
            cnt <= cnt - CNT_W'(1);
        end
    end

    assign done = (cnt == CNT_W'(1));  // last count

    // one access at a time
    a_no_restart: assert property (@(posedge clk) disable iff (!rst_b) start |-> cnt == '0)
        else $error("mem_wait_timer restarted while running");

endmodule

// File: hw/data_ram.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module data_ram import core_pkg::*; (
    input  logic       clk,
    input  logic       we,
    input  dmem_addr_t addr,
    input  word_t      wdata,
    output word_t      rdata
);

    word_t mem [`CORE_DMEM_DEPTH];

    // read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: hw/exec_fsm.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module exec_fsm import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_b,
    input  logic       instr_valid,
    input  instr_in_t  instr,
    input  ctrl_t      ctrl,
    input  word_t      rs_data,
    input  word_t      rt_data,
    input  word_t      alu_y,
    input  logic       alu_zero,
    input  word_t      ram_rdata,
    input  logic       timer_done,
    output word_t      held_word,
    output logic       timer_start,
    output logic       ram_we,
    output dmem_addr_t ram_addr,
    output word_t      ram_wdata,
    output logic       rf_wr_en,
    output reg_idx_t   rf_wr_reg,
    output word_t      rf_wr_data,
    output logic       busy,
    output logic       halted,
    output logic       retire_valid,
    output retire_t    retire
);

    exec_state_t state, state_nxt;
    instr_in_t   instr_q;
    logic        accept;
    logic        is_mem;
    logic        taken;
    word_t       imm_sext;
    word_t       ea;
    word_t       pc_plus4;
    word_t       br_target;
    word_t       jmp_target;

    // new work only when nothing is in flight
    assign accept = instr_valid && (state == s_idle || state == s_retire);
    assign is_mem = ctrl.is_load || ctrl.is_store;

    always_comb begin
        state_nxt = state;
        case (state)
            s_idle:     if (accept) state_nxt = s_exec;
            s_exec:     state_nxt = ctrl.halt ? s_halted : (is_mem ? s_mem_wait : s_retire);
            s_mem_wait: if (timer_done) state_nxt = s_retire;
            s_retire:   state_nxt = accept ? s_exec : s_idle;
            s_halted:   state_nxt = s_halted;  // until reset
            default:    state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            state <= s_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
    end

    assign held_word = instr_q.word;

    assign imm_sext = {{16{instr_q.word[15]}}, instr_q.word[15:0]};
    assign ea = rs_data + imm_sext;
    assign ram_addr = ea[`CORE_DMEM_ADDR_W+1:2];  // word index
    assign ram_wdata = rt_data;
    assign ram_we = (state == s_exec) && ctrl.is_store;  // store lands as the wait begins
    assign timer_start = (state == s_exec) && is_mem;

    assign pc_plus4 = instr_q.pc + 32'd4;
    assign br_target = pc_plus4 + {imm_sext[29:0], 2'b00};
    assign jmp_target = {pc_plus4[31:28], instr_q.word[25:0], 2'b00};
    // eq gives y of 1 on a match, so zero means not equal
    assign taken = (ctrl.branch_eq && !alu_zero) || (ctrl.branch_ne && alu_zero);

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            retire <= '0;
        end else if (state == s_exec && !ctrl.halt && !is_mem) begin
            retire.wr_en <= ctrl.wr_en;
            retire.wr_reg <= ctrl.wr_reg;
            retire.wr_data <= !ctrl.wr_en ? '0 :
                              ctrl.is_lui ? {instr_q.word[15:0], 16'h0000} : alu_y;
            retire.redirect_en <= taken || ctrl.is_jump;
            retire.redirect_pc <= ctrl.is_jump ? jmp_target : (taken ? br_target : '0);
        end else if (state == s_mem_wait && timer_done) begin
            retire.wr_en <= ctrl.is_load;
            retire.wr_reg <= ctrl.wr_reg;
            retire.wr_data <= ctrl.is_load ? ram_rdata : '0;
            retire.redirect_en <= 1'b0;
            retire.redirect_pc <= '0;
        end
    end

    // write back on the retire edge
    assign rf_wr_en = (state == s_retire) && retire.wr_en;
    assign rf_wr_reg = retire.wr_reg;
    assign rf_wr_data = retire.wr_data;

    assign retire_valid = (state == s_retire);
    assign busy = (state == s_exec) || (state == s_mem_wait);
    assign halted = (state == s_halted);

    a_no_strobe_busy: assert property (@(posedge clk) disable iff (!rst_b)
        instr_valid |-> !busy)
        else $error("instr_valid strobed while core busy");

    // memory latency seen by the FSM matches the configured wait
    a_wait_len: assert property (@(posedge clk) disable iff (!rst_b)
        timer_start |-> ##(`CORE_MEM_WAIT) timer_done)
        else $error("memory wait length mismatch");

endmodule

// File: hw/mips_core.sv
`timescale 1ns/1ps

module mips_core import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_b,
    input  logic      instr_valid,
    input  instr_in_t instr,
    output logic      busy,
    output logic      halted,
    output logic      retire_valid,
    output retire_t   retire
);

    ctrl_t      ctrl;
    word_t      held_word;
    word_t      rs_data, rt_data;
    word_t      alu_a, alu_b, alu_y;
    logic       alu_zero;
    logic       timer_start, timer_done;
    logic       ram_we;
    dmem_addr_t ram_addr;
    word_t      ram_wdata, ram_rdata;
    logic       rf_wr_en;
    reg_idx_t   rf_wr_reg;
    word_t      rf_wr_data;

    // operand select
    assign alu_a = ctrl.a_is_rt ? rt_data : rs_data;

    always_comb begin
        case (ctrl.b_sel)
            b_imm_sext: alu_b = {{16{held_word[15]}}, held_word[15:0]};
            b_imm_zext: alu_b = {16'h0000, held_word[15:0]};
            b_shamt:    alu_b = {27'd0, held_word[10:6]};
            b_rs:       alu_b = rs_data;   // variable shifts
            default:    alu_b = rt_data;
        endcase
    end

    exec_fsm u_fsm (
        .clk, .rst_b, .instr_valid, .instr, .ctrl, .rs_data, .rt_data,
        .alu_y, .alu_zero, .ram_rdata, .timer_done, .held_word, .timer_start,
        .ram_we, .ram_addr, .ram_wdata, .rf_wr_en, .rf_wr_reg, .rf_wr_data,
        .busy, .halted, .retire_valid, .retire
    );

    instr_decode u_dec (.word(held_word), .ctrl(ctrl));

    reg_file u_rf (
        .clk, .rst_b,
        .rs(held_word[25:21]), .rt(held_word[20:16]),
        .rs_data, .rt_data,
        .wr_en(rf_wr_en), .wr_reg(rf_wr_reg), .wr_data(rf_wr_data)
    );

    alu u_alu (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .y(alu_y), .zero(alu_zero));

    mem_wait_timer u_timer (.clk, .rst_b, .start(timer_start), .done(timer_done));

    data_ram u_ram (.clk, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata));

endmodule

// File: sim/tb_mips_core.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_mips_core import core_pkg::*; #(
    parameter int unsigned SEED = 32'h07c5_7499
);

    localparam int N_FILL     = 2 * 31;  // lui then addi per register
    localparam int N_RTYPE    = 200;
    localparam int N_ITYPE    = 100;
    localparam int N_PAIRS    = 40;      // each is a sw and a lw
    localparam int N_BRANCH   = 60;
    localparam int NUM_INSTR  = N_FILL + N_RTYPE + N_ITYPE + 2 * N_PAIRS + N_BRANCH + 2;
    localparam int MEM_LAT    = 2 + `CORE_MEM_WAIT;
    localparam int MAX_WAIT   = `CORE_MEM_WAIT + 4;
    localparam int TIMEOUT_NS = (NUM_INSTR * (`CORE_MEM_WAIT + 4) + 100) * 10;

    logic      clk;
    logic      rst_b;
    logic      instr_valid;
    instr_in_t instr;
    logic      busy;
    logic      halted;
    logic      retire_valid;
    retire_t   retire;

    // reference model state
    word_t regs_m [32];
    word_t mem_m [`CORE_DMEM_DEPTH];
    word_t pc;

    funct_t  r_functs [13] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                               6'h00, 6'h02, 6'h03, 6'h04, 6'h06};
    opcode_t i_ops [6] = '{6'h08, 6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

    mips_core dut (
        .clk, .rst_b, .instr_valid, .instr, .busy, .halted, .retire_valid, .retire
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "check of %s failed", name);
        end
    endtask

    task automatic fail_run(input string why);
        $display("error at %0t: %s", $time, why);
        $display("RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    function automatic word_t sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic word_t read_reg(input reg_idx_t r);
        return (r == '0) ? 32'd0 : regs_m[r];  // $zero reads as zero
    endfunction

    function automatic reg_idx_t pick_reg();
        word_t r;
        r = $urandom;
        return r[4:0];
    endfunction

    function automatic word_t r_word(input reg_idx_t rs, input reg_idx_t rt, input reg_idx_t rd,
                                     input logic [4:0] sh, input funct_t fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_word(input opcode_t op, input reg_idx_t rs, input reg_idx_t rt,
                                     input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_word(input logic [25:0] idx);
        return {6'b000010, idx};
    endfunction

    // mips semantics for the kept r-type functs
    function automatic word_t rtype_model(input funct_t fn, input word_t a, input word_t b,
                                          input logic [4:0] sh);
        case (fn)
            6'h20, 6'h21: return a + b;
            6'h22, 6'h23: return a - b;
            6'h24:        return a & b;
            6'h25:        return a | b;
            6'h26:        return a ^ b;
            6'h27:        return ~(a | b);
            6'h00:        return b << sh;
            6'h02:        return b >> sh;
            6'h03:        return word_t'($signed(b) >>> sh);
            6'h04:        return b << a[4:0];  // sllv
            6'h06:        return b >> a[4:0];  // srlv
            default:      return '0;
        endcase
    endfunction

    function automatic word_t itype_model(input opcode_t op, input word_t a,
                                          input logic [15:0] imm);
        case (op)
            6'h08, 6'h09: return a + sext16(imm);
            6'h0c:        return a & {16'h0000, imm};
            6'h0d:        return a | {16'h0000, imm};
            6'h0e:        return a ^ {16'h0000, imm};
            6'h0f:        return {imm, 16'h0000};
            default:      return '0;
        endcase
    endfunction

    // issue one instruction, wait for its retire and compare with the model
    task automatic execute(input word_t word, input logic wr_en, input reg_idx_t wr_reg,
                           input word_t wr_data, input logic redir, input word_t redir_pc,
                           input int lat);
        int cycles;
        if (busy || halted) begin
            fail_run("core not ready when an instruction was due");
        end
        instr.word = word;
        instr.pc = pc;
        instr_valid = 1'b1;
        @(posedge clk);  // accept edge
        #1;
        instr_valid = 1'b0;
        cycles = 0;
        while (!retire_valid) begin
            check_eq("busy", 32'(busy), 32'd1);
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > MAX_WAIT) begin
                fail_run("no retire strobe within the expected number of cycles");
            end
        end
        check_eq("latency", cycles + 1, lat);  // plus the cycle the strobe was driven in
        check_eq("retire.wr_en", 32'(retire.wr_en), 32'(wr_en));
        if (wr_en) begin
            check_eq("retire.wr_reg", 32'(retire.wr_reg), 32'(wr_reg));
            check_eq("retire.wr_data", retire.wr_data, wr_data);
        end
        check_eq("retire.redirect_en", 32'(retire.redirect_en), 32'(redir));
        if (redir) begin
            check_eq("retire.redirect_pc", retire.redirect_pc, redir_pc);
        end
        if (wr_en && wr_reg != '0) begin
            regs_m[wr_reg] = wr_data;
        end
        pc = redir ? redir_pc : pc + 32'd4;
    endtask

    task automatic await_halt(input word_t word);
        int cycles;
        instr.word = word;
        instr.pc = pc;
        instr_valid = 1'b1;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        cycles = 0;
        while (!halted) begin
            check_eq("retire_valid", 32'(retire_valid), 32'd0);
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > MAX_WAIT) begin
                fail_run("halted never rose after the syscall");
            end
        end
        check_eq("halt latency", cycles + 1, 2);
        check_eq("retire_valid", 32'(retire_valid), 32'd0);
    endtask

    task automatic fill_regs();
        word_t    rnd;
        reg_idx_t rr;
        for (int r = 1; r < 32; r++) begin
            rnd = $urandom;
            rr = reg_idx_t'(r);
            execute(i_word(6'h0f, 5'd0, rr, rnd[31:16]), 1'b1, rr, {rnd[31:16], 16'h0000},
                    1'b0, '0, 2);
            execute(i_word(6'h08, rr, rr, rnd[15:0]), 1'b1, rr,
                    regs_m[r] + sext16(rnd[15:0]), 1'b0, '0, 2);
        end
    endtask

    task automatic alu_sweep();
        funct_t     fn;
        reg_idx_t   rs, rt, rd;
        logic [4:0] sh;
        word_t      res;
        for (int i = 0; i < N_RTYPE; i++) begin
            fn = r_functs[$urandom_range(0, 12)];
            rs = pick_reg();
            rt = pick_reg();
            rd = pick_reg();
            sh = pick_reg();
            if (fn == 6'h00 || fn == 6'h02 || fn == 6'h03) begin
                rs = '0;  // shamt forms
            end else begin
                sh = '0;
            end
            res = rtype_model(fn, read_reg(rs), read_reg(rt), sh);
            execute(r_word(rs, rt, rd, sh, fn), 1'b1, rd, res, 1'b0, '0, 2);
        end
    endtask

    task automatic imm_sweep();
        opcode_t  op;
        reg_idx_t rs, rt;
        word_t    rnd;
        word_t    res;
        for (int i = 0; i < N_ITYPE; i++) begin
            op = i_ops[$urandom_range(0, 5)];
            rs = (op == 6'h0f) ? 5'd0 : pick_reg();
            rt = pick_reg();
            rnd = $urandom;
            res = itype_model(op, read_reg(rs), rnd[15:0]);
            execute(i_word(op, rs, rt, rnd[15:0]), 1'b1, rt, res, 1'b0, '0, 2);
        end
    endtask

    task automatic store_load_pairs();
        reg_idx_t   base, src, dst;
        word_t      rnd, ea;
        dmem_addr_t idx;
        for (int i = 0; i < N_PAIRS; i++) begin
            base = pick_reg();
            src = pick_reg();
            dst = pick_reg();
            rnd = $urandom;
            ea = read_reg(base) + sext16(rnd[15:0]);
            idx = ea[`CORE_DMEM_ADDR_W+1:2];
            execute(i_word(6'h2b, base, src, rnd[15:0]), 1'b0, '0, '0, 1'b0, '0, MEM_LAT);
            mem_m[idx] = read_reg(src);
            execute(i_word(6'h23, base, dst, rnd[15:0]), 1'b1, dst, mem_m[idx], 1'b0, '0,
                    MEM_LAT);
        end
    endtask

    task automatic branch_sweep();
        reg_idx_t rs, rt;
        word_t    rnd, target;
        logic     taken;
        int       kind;
        for (int i = 0; i < N_BRANCH; i++) begin
            rnd = $urandom;
            pc = {rnd[31:2], 2'b00};
            kind = $urandom_range(0, 2);  // beq, bne, j
            rnd = $urandom;
            if (kind == 2) begin
                target = pc + 32'd4;
                target = {target[31:28], rnd[25:0], 2'b00};
                execute(j_word(rnd[25:0]), 1'b0, '0, '0, 1'b1, target, 2);
            end else begin
                rs = pick_reg();
                rt = rnd[16] ? rs : pick_reg();  // equal operands half the time
                taken = (read_reg(rs) == read_reg(rt)) ^ (kind == 1);
                target = pc + 32'd4 + (sext16(rnd[15:0]) << 2);
                execute(i_word((kind == 0) ? 6'h04 : 6'h05, rs, rt, rnd[15:0]), 1'b0, '0, '0,
                        taken, target, 2);
            end
        end
    endtask

    task automatic halt_sequence();
        await_halt(r_word('0, '0, '0, '0, 6'h0c));  // syscall
        // strobe once more, the core must stay halted
        instr.word = i_word(6'h08, 5'd0, 5'd1, 16'h0001);
        instr_valid = 1'b1;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        repeat (2 * MAX_WAIT) begin
            check_eq("retire_valid", 32'(retire_valid), 32'd0);
            check_eq("halted", 32'(halted), 32'd1);
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_b = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_b = 1'b1;
        check_eq("busy", 32'(busy), 32'd0);
        check_eq("halted", 32'(halted), 32'd0);
        check_eq("retire_valid", 32'(retire_valid), 32'd0);
        check_eq("retire.wr_en", 32'(retire.wr_en), 32'd0);
        check_eq("retire.wr_reg", 32'(retire.wr_reg), 32'd0);
        check_eq("retire.wr_data", retire.wr_data, 32'd0);
        check_eq("retire.redirect_en", 32'(retire.redirect_en), 32'd0);
        check_eq("retire.redirect_pc", retire.redirect_pc, 32'd0);
        fill_regs();
        alu_sweep();
        imm_sweep();
        store_load_pairs();
        branch_sweep();
        halt_sequence();
        $display("RESULT: PASS");
        $finish;
    end

    // sized from the instruction count with a worst case per instruction
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: test did not finish within %0d ns", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: tb.f
+incdir+hw
hw/core_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/mem_wait_timer.sv
hw/data_ram.sv
hw/exec_fsm.sv
hw/mips_core.sv
sim/tb_mips_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_core
# decimal form of 32'h07c5_7499
SEED      ?= 130380953
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f

VFLAGS ?= --timing --assert -f $(FILELIST) --top-module $(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -GSEED=$(SEED) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
